// File: design/stlb_pkg.sv
package stlb_pkg;

	// ===================================================================
	// Sizes
	// ===================================================================

	localparam int CHANNELS = 4;
	localparam int ASSOC = 4;
	localparam int LOG_ENTRIES = 4;
	localparam int ENTRIES = 1 << LOG_ENTRIES;

	// 64kB pages, set index sits right above the page offset
	localparam int PAGE_BITS = 16;
	localparam int VADDR_BITS = 32;
	localparam int PADDR_BITS = 32;
	localparam int TAG_LSB = PAGE_BITS + LOG_ENTRIES;

	// ===================================================================
	// Types
	// ===================================================================

	typedef logic [VADDR_BITS-1:0] vaddr_t;
	typedef logic [PADDR_BITS-1:0] paddr_t;
	typedef logic [7:0] asid_t;
	typedef logic [PADDR_BITS-PAGE_BITS-1:0] ppn_t;
	typedef logic [VADDR_BITS-TAG_LSB-1:0] tag_t;
	typedef logic [LOG_ENTRIES-1:0] index_t;
	typedef logic [$clog2(ASSOC)-1:0] way_t;
	typedef logic [$clog2(CHANNELS)-1:0] chan_t;

	// Bit 2 read, bit 1 write, bit 0 execute
	typedef logic [2:0] rwx_t;
	localparam int RWX_W = 1;
	localparam rwx_t RWX_ALL = 3'b111;

	typedef enum logic [1:0] {
		MODE_USER    = 2'd0,
		MODE_SUPER   = 2'd1,
		MODE_HYPER   = 2'd2,
		MODE_MACHINE = 2'd3
	} mode_t;

	// One stored translation
	typedef struct packed {
		logic  valid;
		logic  global;
		asid_t asid;
		tag_t  tag;
		ppn_t  ppn;
		rwx_t  urwx;
		rwx_t  srwx;
		rwx_t  hrwx;
	} tlb_entry_t;

endpackage

// File: design/stlb_req_arbiter.sv
`timescale 1ns/10ps

module stlb_req_arbiter (
	input  logic                                      clk_g,
	input  logic                                      rst_i,
	input  logic [stlb_pkg::CHANNELS-1:0]             req_i,
	input  stlb_pkg::vaddr_t [stlb_pkg::CHANNELS-1:0] req_vadr_i,
	input  stlb_pkg::asid_t [stlb_pkg::CHANNELS-1:0]  req_asid_i,
	input  stlb_pkg::mode_t [stlb_pkg::CHANNELS-1:0]  req_mode_i,
	input  logic [stlb_pkg::CHANNELS-1:0]             req_we_i,
	input  logic                                      rdy_i,
	output logic [stlb_pkg::CHANNELS-1:0]             rty_o,
	output logic                                      iss_valid_o,
	output stlb_pkg::chan_t                           iss_chan_o,
	output stlb_pkg::vaddr_t                          iss_vadr_o,
	output stlb_pkg::asid_t                           iss_asid_o,
	output stlb_pkg::mode_t                           iss_mode_o,
	output logic                                      iss_we_o,
	output stlb_pkg::index_t                          iss_index_o
);

	stlb_pkg::chan_t last_q;
	stlb_pkg::chan_t win_chan;
	logic win_found;
	logic take;
	logic [stlb_pkg::CHANNELS-1:0] win_mask;

	// First strobing channel after the last winner
	always_comb begin : pick
		stlb_pkg::chan_t cand;
		win_found = 1'b0;
		win_chan = last_q;
		for (int k = 1; k <= stlb_pkg::CHANNELS; k++) begin
			cand = stlb_pkg::chan_t'((int'(last_q) + k) % stlb_pkg::CHANNELS);
			if (!win_found && req_i[cand]) begin
				win_found = 1'b1;
				win_chan = cand;
			end
		end
	end

	assign take = rdy_i & win_found;
	assign win_mask = {{(stlb_pkg::CHANNELS-1){1'b0}}, 1'b1} << win_chan;

	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			// Channel 0 has first pick out of reset
			last_q <= stlb_pkg::chan_t'(stlb_pkg::CHANNELS - 1);
			iss_valid_o <= 1'b0;
			rty_o <= '0;
		end else begin
			iss_valid_o <= take;
			// Busy table retries everyone
			rty_o <= take ? (req_i & ~win_mask) : req_i;
			if (take) begin
				last_q <= win_chan;
			end
		end
	end

	// Winner's fields, held until the next issue
	always_ff @(posedge clk_g) begin
		if (take) begin
			iss_chan_o <= win_chan;
			iss_vadr_o <= req_vadr_i[win_chan];
			iss_asid_o <= req_asid_i[win_chan];
			iss_mode_o <= req_mode_i[win_chan];
			iss_we_o <= req_we_i[win_chan];
			iss_index_o <= req_vadr_i[win_chan][stlb_pkg::PAGE_BITS +: stlb_pkg::LOG_ENTRIES];
		end
	end

endmodule

// File: design/stlb_entry_ram.sv
`timescale 1ns/10ps

module stlb_entry_ram (
	input  logic                                         clk_g,
	input  logic                                         wr_i,
	input  logic [stlb_pkg::ASSOC-1:0]                   wr_ways_i,
	input  stlb_pkg::index_t                             wr_index_i,
	input  stlb_pkg::tlb_entry_t                         wr_entry_i,
	input  logic                                         rd_i,
	input  stlb_pkg::index_t                             rd_index_i,
	output stlb_pkg::tlb_entry_t [stlb_pkg::ASSOC-1:0]   rd_entries_o
);

	// One array per way, all indexed by the same set
	stlb_pkg::tlb_entry_t mem [stlb_pkg::ASSOC][stlb_pkg::ENTRIES];

	// ===================================================================
	// Write port
	// ===================================================================

	// Several ways may take the same entry in one cycle, which is
	// how the invalidate walk clears a whole set
	always_ff @(posedge clk_g) begin
		if (wr_i) begin
			for (int w = 0; w < stlb_pkg::ASSOC; w++) begin
				if (wr_ways_i[w]) begin
					mem[w][wr_index_i] <= wr_entry_i;
				end
			end
		end
	end

	// ===================================================================
	// Read port
	// ===================================================================

	// Every way comes out together for the tag compare.
	// Output holds its value between reads
	always_ff @(posedge clk_g) begin
		if (rd_i) begin
			for (int w = 0; w < stlb_pkg::ASSOC; w++) begin
				rd_entries_o[w] <= mem[w][rd_index_i];
			end
		end
	end

endmodule

// File: design/stlb_update.sv
`timescale 1ns/10ps

module stlb_update (
	input  logic                          clk_g,
	input  logic                          rst_i,
	input  logic                          upd_we_i,
	input  stlb_pkg::vaddr_t              upd_vadr_i,
	input  stlb_pkg::asid_t               upd_asid_i,
	input  logic                          upd_global_i,
	input  stlb_pkg::ppn_t                upd_ppn_i,
	input  stlb_pkg::rwx_t                upd_urwx_i,
	input  stlb_pkg::rwx_t                upd_srwx_i,
	input  stlb_pkg::rwx_t                upd_hrwx_i,
	input  stlb_pkg::way_t                upd_way_i,
	input  logic                          upd_rand_i,
	input  logic                          inv_all_i,
	output logic                          rdy_o,
	output logic                          wr_o,
	output logic [stlb_pkg::ASSOC-1:0]    wr_ways_o,
	output stlb_pkg::index_t              wr_index_o,
	output stlb_pkg::tlb_entry_t          wr_entry_o
);

	logic walk_q;
	stlb_pkg::index_t walk_idx_q;
	stlb_pkg::way_t rand_way_q;
	stlb_pkg::way_t sel_way;
	stlb_pkg::tlb_entry_t new_entry;
	logic upd_q;
	logic [stlb_pkg::ASSOC-1:0] upd_ways_q;
	stlb_pkg::index_t upd_index_q;
	stlb_pkg::tlb_entry_t upd_entry_q;

	always_comb begin
		new_entry.valid = 1'b1;
		new_entry.global = upd_global_i;
		new_entry.asid = upd_asid_i;
		new_entry.tag = upd_vadr_i[stlb_pkg::VADDR_BITS-1:stlb_pkg::TAG_LSB];
		new_entry.ppn = upd_ppn_i;
		new_entry.urwx = upd_urwx_i;
		new_entry.srwx = upd_srwx_i;
		new_entry.hrwx = upd_hrwx_i;
	end

	assign sel_way = upd_rand_i ? rand_way_q : upd_way_i;

	// ===================================================================
	// Walk and way counter
	// ===================================================================

	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			// Walk starts by itself out of reset
			walk_q <= 1'b1;
			walk_idx_q <= '0;
			rand_way_q <= '0;
			upd_q <= 1'b0;
		end else begin
			// An invalidate in the same cycle wins over the write
			upd_q <= upd_we_i & rdy_o & ~inv_all_i;
			if (!upd_we_i) begin
				rand_way_q <= rand_way_q + 1'b1;
			end
			if (walk_q) begin
				walk_idx_q <= walk_idx_q + 1'b1;
				if (walk_idx_q == stlb_pkg::index_t'(stlb_pkg::ENTRIES - 1)) begin
					walk_q <= 1'b0;
				end
			end else if (inv_all_i) begin
				walk_q <= 1'b1;
				walk_idx_q <= '0;
			end
		end
	end

	always_ff @(posedge clk_g) begin
		if (upd_we_i) begin
			upd_ways_q <= {{(stlb_pkg::ASSOC-1){1'b0}}, 1'b1} << sel_way;
			upd_index_q <= upd_vadr_i[stlb_pkg::PAGE_BITS +: stlb_pkg::LOG_ENTRIES];
			upd_entry_q <= new_entry;
		end
	end

	// Walk clears all ways of one set per cycle
	assign rdy_o = ~walk_q;
	assign wr_o = walk_q | upd_q;
	assign wr_ways_o = walk_q ? '1 : upd_ways_q;
	assign wr_index_o = walk_q ? walk_idx_q : upd_index_q;
	assign wr_entry_o = walk_q ? '0 : upd_entry_q;

	a_upd_when_ready: assert property (@(posedge clk_g) disable iff (rst_i)
		upd_we_i |-> rdy_o);

endmodule

// File: design/stlb_translate.sv
`timescale 1ns/10ps

module stlb_translate (
	input  logic                                        clk_g,
	input  logic                                        rst_i,
	input  logic                                        iss_valid_i,
	input  stlb_pkg::chan_t                             iss_chan_i,
	input  stlb_pkg::vaddr_t                            iss_vadr_i,
	input  stlb_pkg::asid_t                             iss_asid_i,
	input  stlb_pkg::mode_t                             iss_mode_i,
	input  logic                                        iss_we_i,
	input  stlb_pkg::tlb_entry_t [stlb_pkg::ASSOC-1:0]  rd_entries_i,
	output logic                                        res_valid_o,
	output stlb_pkg::chan_t                             res_chan_o,
	output stlb_pkg::paddr_t                            res_padr_o,
	output stlb_pkg::rwx_t                              res_rwx_o,
	output logic                                        res_we_o,
	output logic                                        res_miss_o
);

	// Request fields one cycle late, lined up with RAM data
	logic vld_q;
	stlb_pkg::chan_t chan_q;
	stlb_pkg::vaddr_t vadr_q;
	stlb_pkg::asid_t asid_q;
	stlb_pkg::mode_t mode_q;
	logic we_q;

	stlb_pkg::tag_t req_tag;
	logic [stlb_pkg::ASSOC-1:0] hit;
	logic any_hit;
	stlb_pkg::tlb_entry_t hit_entry;
	stlb_pkg::rwx_t mode_rwx;

	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			vld_q <= 1'b0;
		end else begin
			vld_q <= iss_valid_i;
		end
	end

	always_ff @(posedge clk_g) begin
		chan_q <= iss_chan_i;
		vadr_q <= iss_vadr_i;
		asid_q <= iss_asid_i;
		mode_q <= iss_mode_i;
		we_q <= iss_we_i;
	end

	// ===================================================================
	// Tag compare
	// ===================================================================

	assign req_tag = vadr_q[stlb_pkg::VADDR_BITS-1:stlb_pkg::TAG_LSB];

	// Global entries ignore the ASID
	always_comb begin
		for (int w = 0; w < stlb_pkg::ASSOC; w++) begin
			hit[w] = rd_entries_i[w].valid &&
				rd_entries_i[w].tag == req_tag &&
				(rd_entries_i[w].global || rd_entries_i[w].asid == asid_q);
		end
	end

	assign any_hit = |hit;

	always_comb begin
		hit_entry = '0;
		for (int w = 0; w < stlb_pkg::ASSOC; w++) begin
			if (hit[w]) begin
				hit_entry = rd_entries_i[w];
			end
		end
	end

	// Machine mode is never restricted
	always_comb begin
		case (mode_q)
		stlb_pkg::MODE_USER:  mode_rwx = hit_entry.urwx;
		stlb_pkg::MODE_SUPER: mode_rwx = hit_entry.srwx;
		stlb_pkg::MODE_HYPER: mode_rwx = hit_entry.hrwx;
		default:              mode_rwx = stlb_pkg::RWX_ALL;
		endcase
	end

	// ===================================================================
	// Result
	// ===================================================================

	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			res_valid_o <= 1'b0;
		end else begin
			res_valid_o <= vld_q;
		end
	end

	always_ff @(posedge clk_g) begin
		if (vld_q) begin
			res_chan_o <= chan_q;
			res_miss_o <= ~any_hit;
			res_padr_o <= any_hit ? {hit_entry.ppn, vadr_q[stlb_pkg::PAGE_BITS-1:0]} : '0;
			res_rwx_o <= any_hit ? mode_rwx : '0;
			res_we_o <= any_hit & we_q & mode_rwx[stlb_pkg::RWX_W];
		end
	end

	// Software never places one page in two ways of a set
	a_single_hit: assert property (@(posedge clk_g) disable iff (rst_i)
		vld_q |-> $onehot0(hit));

endmodule

// File: design/stlb_top.sv
`timescale 1ns/10ps

module stlb_top (
	input  logic                                      clk_g,
	input  logic                                      rst_i,
	// Requesting channels
	input  logic [stlb_pkg::CHANNELS-1:0]             req_i,
	input  stlb_pkg::vaddr_t [stlb_pkg::CHANNELS-1:0] req_vadr_i,
	input  stlb_pkg::asid_t [stlb_pkg::CHANNELS-1:0]  req_asid_i,
	input  stlb_pkg::mode_t [stlb_pkg::CHANNELS-1:0]  req_mode_i,
	input  logic [stlb_pkg::CHANNELS-1:0]             req_we_i,
	output logic [stlb_pkg::CHANNELS-1:0]             rty_o,
	// Software update
	input  logic                                      upd_we_i,
	input  stlb_pkg::vaddr_t                          upd_vadr_i,
	input  stlb_pkg::asid_t                           upd_asid_i,
	input  logic                                      upd_global_i,
	input  stlb_pkg::ppn_t                            upd_ppn_i,
	input  stlb_pkg::rwx_t                            upd_urwx_i,
	input  stlb_pkg::rwx_t                            upd_srwx_i,
	input  stlb_pkg::rwx_t                            upd_hrwx_i,
	input  stlb_pkg::way_t                            upd_way_i,
	input  logic                                      upd_rand_i,
	input  logic                                      inv_all_i,
	output logic                                      rdy_o,
	// Translation result
	output logic                                      res_valid_o,
	output stlb_pkg::chan_t                           res_chan_o,
	output stlb_pkg::paddr_t                          res_padr_o,
	output stlb_pkg::rwx_t                            res_rwx_o,
	output logic                                      res_we_o,
	output logic                                      res_miss_o
);

	logic wr;
	logic [stlb_pkg::ASSOC-1:0] wr_ways;
	stlb_pkg::index_t wr_index;
	stlb_pkg::tlb_entry_t wr_entry;

	logic iss_valid;
	stlb_pkg::chan_t iss_chan;
	stlb_pkg::vaddr_t iss_vadr;
	stlb_pkg::asid_t iss_asid;
	stlb_pkg::mode_t iss_mode;
	logic iss_we;
	stlb_pkg::index_t iss_index;

	stlb_pkg::tlb_entry_t [stlb_pkg::ASSOC-1:0] rd_entries;

	stlb_req_arbiter u_arbiter (
		.clk_g       (clk_g),
		.rst_i       (rst_i),
		.req_i       (req_i),
		.req_vadr_i  (req_vadr_i),
		.req_asid_i  (req_asid_i),
		.req_mode_i  (req_mode_i),
		.req_we_i    (req_we_i),
		.rdy_i       (rdy_o),
		.rty_o       (rty_o),
		.iss_valid_o (iss_valid),
		.iss_chan_o  (iss_chan),
		.iss_vadr_o  (iss_vadr),
		.iss_asid_o  (iss_asid),
		.iss_mode_o  (iss_mode),
		.iss_we_o    (iss_we),
		.iss_index_o (iss_index)
	);

	stlb_entry_ram u_ram (
		.clk_g        (clk_g),
		.wr_i         (wr),
		.wr_ways_i    (wr_ways),
		.wr_index_i   (wr_index),
		.wr_entry_i   (wr_entry),
		.rd_i         (iss_valid),
		.rd_index_i   (iss_index),
		.rd_entries_o (rd_entries)
	);

	stlb_update u_update (
		.clk_g        (clk_g),
		.rst_i        (rst_i),
		.upd_we_i     (upd_we_i),
		.upd_vadr_i   (upd_vadr_i),
		.upd_asid_i   (upd_asid_i),
		.upd_global_i (upd_global_i),
		.upd_ppn_i    (upd_ppn_i),
		.upd_urwx_i   (upd_urwx_i),
		.upd_srwx_i   (upd_srwx_i),
		.upd_hrwx_i   (upd_hrwx_i),
		.upd_way_i    (upd_way_i),
		.upd_rand_i   (upd_rand_i),
		.inv_all_i    (inv_all_i),
		.rdy_o        (rdy_o),
		.wr_o         (wr),
		.wr_ways_o    (wr_ways),
		.wr_index_o   (wr_index),
		.wr_entry_o   (wr_entry)
	);

	stlb_translate u_translate (
		.clk_g        (clk_g),
		.rst_i        (rst_i),
		.iss_valid_i  (iss_valid),
		.iss_chan_i   (iss_chan),
		.iss_vadr_i   (iss_vadr),
		.iss_asid_i   (iss_asid),
		.iss_mode_i   (iss_mode),
		.iss_we_i     (iss_we),
		.rd_entries_i (rd_entries),
		.res_valid_o  (res_valid_o),
		.res_chan_o   (res_chan_o),
		.res_padr_o   (res_padr_o),
		.res_rwx_o    (res_rwx_o),
		.res_we_o     (res_we_o),
		.res_miss_o   (res_miss_o)
	);

endmodule

// File: test/tb_stlb.sv
`timescale 1ns/10ps

module tb_stlb;

	localparam int TIMEOUT = 100;

	logic clk_g = 1'b0;
	logic rst_i;
	logic [stlb_pkg::CHANNELS-1:0] req_i, req_we_i, rty_o;
	stlb_pkg::vaddr_t [stlb_pkg::CHANNELS-1:0] req_vadr_i;
	stlb_pkg::asid_t [stlb_pkg::CHANNELS-1:0] req_asid_i;
	stlb_pkg::mode_t [stlb_pkg::CHANNELS-1:0] req_mode_i;
	logic upd_we_i, upd_global_i, upd_rand_i, inv_all_i, rdy_o;
	stlb_pkg::vaddr_t upd_vadr_i;
	stlb_pkg::asid_t upd_asid_i;
	stlb_pkg::ppn_t upd_ppn_i;
	stlb_pkg::rwx_t upd_urwx_i, upd_srwx_i, upd_hrwx_i;
	stlb_pkg::way_t upd_way_i;
	logic res_valid_o, res_we_o, res_miss_o;
	stlb_pkg::chan_t res_chan_o;
	stlb_pkg::paddr_t res_padr_o;
	stlb_pkg::rwx_t res_rwx_o;

	int checks = 0;
	int errors = 0;
	int timeouts = 0;
	int lat;
	int wait_cycles;
	logic [31:0] lcg_state = 32'd15;
	stlb_pkg::chan_t last_chan = 2'd3;
	stlb_pkg::vaddr_t filled_va [4];

	stlb_top u_stlb_top (.*);

	always #10 clk_g = ~clk_g;

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// ===================================================================
	// Compare tasks
	// ===================================================================

	task automatic check_paddr(string name, stlb_pkg::paddr_t exp, stlb_pkg::paddr_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_rwx(string name, stlb_pkg::rwx_t exp, stlb_pkg::rwx_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERROR %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_bit(string name, logic exp, logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERROR %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_chan(string name, stlb_pkg::chan_t exp, stlb_pkg::chan_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERROR %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_cycles(string name, int exp, int act);
		checks++;
		if (act != exp) begin
			errors++;
			$display("ERROR %s: expected %0d cycles, actual %0d cycles", name, exp, act);
		end
	endtask

	// ===================================================================
	// Bus drivers
	// ===================================================================

	task automatic wait_ready();
		wait_cycles = 0;
		@(negedge clk_g);
		while (!rdy_o && wait_cycles < TIMEOUT) begin
			@(negedge clk_g);
			wait_cycles++;
		end
		if (!rdy_o) begin
			timeouts++;
			$display("Timeout: the buffer never became ready");
		end
	endtask

	task automatic write_entry(stlb_pkg::vaddr_t va, stlb_pkg::asid_t asid, logic glob,
		stlb_pkg::ppn_t ppn, stlb_pkg::rwx_t urwx, stlb_pkg::rwx_t srwx,
		stlb_pkg::rwx_t hrwx, stlb_pkg::way_t way, logic rnd);
		@(posedge clk_g);
		upd_we_i <= 1'b1;
		upd_vadr_i <= va;
		upd_asid_i <= asid;
		upd_global_i <= glob;
		upd_ppn_i <= ppn;
		upd_urwx_i <= urwx;
		upd_srwx_i <= srwx;
		upd_hrwx_i <= hrwx;
		upd_way_i <= way;
		upd_rand_i <= rnd;
		@(posedge clk_g);
		upd_we_i <= 1'b0;
	endtask

	// Counts rising edges from the strobe until the result pulse shows
	task automatic await_result();
		lat = 0;
		do begin
			@(posedge clk_g);
			req_i <= '0;
			lat++;
			@(negedge clk_g);
		end while (!res_valid_o && lat < TIMEOUT);
		if (!res_valid_o) begin
			timeouts++;
			$display("Timeout: no translation result came back");
		end
	endtask

	task automatic lookup(stlb_pkg::chan_t ch, stlb_pkg::vaddr_t va, stlb_pkg::asid_t asid,
		stlb_pkg::mode_t mode, logic we);
		@(posedge clk_g);
		req_i <= '0;
		req_i[ch] <= 1'b1;
		req_vadr_i[ch] <= va;
		req_asid_i[ch] <= asid;
		req_mode_i[ch] <= mode;
		req_we_i[ch] <= we;
		last_chan = ch;
		await_result();
	endtask

	task automatic expect_miss(string name);
		check_bit(name, 1'b1, res_miss_o);
		check_paddr(name, '0, res_padr_o);
		check_rwx(name, '0, res_rwx_o);
	endtask

	// ===================================================================
	// Directed tests
	// ===================================================================

	task automatic test_reset_walk();
		check_bit("reset walk busy", 1'b0, rdy_o);
		wait_ready();
		lookup(2'd1, 32'h1234_5678, 8'h01, stlb_pkg::MODE_USER, 1'b0);
		expect_miss("empty table miss");
	endtask

	task automatic test_hit();
		stlb_pkg::rwx_t exp_rwx [4] = '{3'b100, 3'b110, 3'b011, 3'b111};
		write_entry(32'h5A31_0000, 8'h11, 1'b0, 16'hBEEF, 3'b100, 3'b110, 3'b011,
			2'd2, 1'b0);
		for (int m = 0; m < 4; m++) begin
			lookup(2'd1, 32'h5A31_1234, 8'h11, stlb_pkg::mode_t'(m), 1'b1);
			check_cycles("hit latency", 3, lat);
			check_bit("hit miss flag", 1'b0, res_miss_o);
			check_paddr("hit padr", 32'hBEEF_1234, res_padr_o);
			check_rwx("hit rights", exp_rwx[m], res_rwx_o);
			// Write enable survives only with the write right
			check_bit("hit write enable", exp_rwx[m][1], res_we_o);
		end
	endtask

	task automatic test_asid_global();
		write_entry(32'h7C42_0000, 8'h22, 1'b0, 16'h1357, 3'b111, 3'b111, 3'b111,
			2'd0, 1'b0);
		lookup(2'd1, 32'h7C42_0010, 8'h33, stlb_pkg::MODE_USER, 1'b0);
		expect_miss("foreign asid miss");
		write_entry(32'h7C42_0000, 8'h22, 1'b1, 16'h1357, 3'b111, 3'b111, 3'b111,
			2'd0, 1'b0);
		lookup(2'd1, 32'h7C42_0010, 8'h33, stlb_pkg::MODE_USER, 1'b0);
		check_bit("global hit miss flag", 1'b0, res_miss_o);
		check_paddr("global hit padr", 32'h1357_0010, res_padr_o);
	endtask

	task automatic test_arbitration();
		logic [stlb_pkg::CHANNELS-1:0] pending;
		stlb_pkg::chan_t exp_win;
		stlb_pkg::vaddr_t arb_va [4];
		for (int c = 0; c < stlb_pkg::CHANNELS; c++) begin
			arb_va[c] = 32'h5A31_0040 + 32'(c * 256);
		end
		pending = '1;
		for (int r = 0; r < 4 && pending != '0; r++) begin
			// Nearest pending channel after the last winner
			exp_win = last_chan;
			for (int k = stlb_pkg::CHANNELS; k >= 1; k--) begin
				if (pending[(int'(last_chan) + k) % stlb_pkg::CHANNELS]) begin
					exp_win = stlb_pkg::chan_t'((int'(last_chan) + k) % stlb_pkg::CHANNELS);
				end
			end
			@(posedge clk_g);
			req_i <= pending;
			for (int c = 0; c < stlb_pkg::CHANNELS; c++) begin
				req_vadr_i[c] <= arb_va[c];
				req_asid_i[c] <= 8'h11;
				req_mode_i[c] <= stlb_pkg::MODE_SUPER;
				req_we_i[c] <= 1'b0;
			end
			@(posedge clk_g);
			req_i <= '0;
			@(negedge clk_g);
			for (int c = 0; c < stlb_pkg::CHANNELS; c++) begin
				check_bit("arbitration retry", pending[c] && int'(exp_win) != c, rty_o[c]);
			end
			await_result();
			check_chan("arbitration winner", exp_win, res_chan_o);
			check_paddr("arbitration padr", {16'hBEEF, arb_va[exp_win][15:0]}, res_padr_o);
			pending[res_chan_o] = 1'b0;
			last_chan = exp_win;
		end
		if (pending != '0) begin
			errors++;
			$display("Some channels were still not served after four rounds");
		end
	endtask

	task automatic test_pipeline();
		logic [31:0] rnd;
		stlb_pkg::ppn_t ppn;
		stlb_pkg::paddr_t exp_padr [4];
		int got;
		int cyc;
		// Sets 8 to 11 are still empty here
		for (int i = 0; i < 4; i++) begin
			rnd = next_random();
			filled_va[i] = {rnd[31:20], stlb_pkg::index_t'(8 + i), rnd[15:0]};
			rnd = next_random();
			ppn = rnd[31:16];
			exp_padr[i] = {ppn, filled_va[i][15:0]};
			write_entry(filled_va[i], 8'h44, 1'b0, ppn, 3'b111, 3'b111, 3'b111, 2'd0, 1'b1);
		end
		got = 0;
		cyc = 0;
		while (got < 4 && cyc < TIMEOUT) begin
			@(posedge clk_g);
			if (cyc < 4) begin
				req_i <= 4'b0001;
				req_vadr_i[0] <= filled_va[cyc];
				req_asid_i[0] <= 8'h44;
				req_mode_i[0] <= stlb_pkg::MODE_USER;
				req_we_i[0] <= 1'b0;
			end else begin
				req_i <= '0;
			end
			cyc++;
			@(negedge clk_g);
			if (res_valid_o) begin
				check_paddr("pipelined padr", exp_padr[got], res_padr_o);
				got++;
			end
		end
		last_chan = '0;
		if (got < 4) begin
			timeouts++;
			$display("Timeout: pipelined lookups returned only %0d results", got);
		end
	endtask

	task automatic test_invalidate();
		@(posedge clk_g);
		inv_all_i <= 1'b1;
		@(posedge clk_g);
		inv_all_i <= 1'b0;
		wait_ready();
		check_cycles("invalidate walk", stlb_pkg::ENTRIES, wait_cycles);
		lookup(2'd1, 32'h5A31_1234, 8'h11, stlb_pkg::MODE_MACHINE, 1'b0);
		expect_miss("invalidated page miss");
		lookup(2'd1, 32'h7C42_0010, 8'h33, stlb_pkg::MODE_USER, 1'b0);
		expect_miss("invalidated global miss");
		for (int i = 0; i < 4; i++) begin
			lookup(2'd0, filled_va[i], 8'h44, stlb_pkg::MODE_USER, 1'b0);
			expect_miss("invalidated random way miss");
		end
	endtask

	initial begin
		rst_i = 1'b1;
		req_i = '0;
		req_we_i = '0;
		req_vadr_i = '0;
		req_asid_i = '0;
		req_mode_i = {stlb_pkg::CHANNELS{stlb_pkg::MODE_USER}};
		upd_we_i = 1'b0;
		upd_vadr_i = '0;
		upd_asid_i = '0;
		upd_global_i = 1'b0;
		upd_ppn_i = '0;
		upd_urwx_i = '0;
		upd_srwx_i = '0;
		upd_hrwx_i = '0;
		upd_way_i = '0;
		upd_rand_i = 1'b0;
		inv_all_i = 1'b0;
		repeat (3) @(posedge clk_g);
		rst_i <= 1'b0;
		test_reset_walk();
		test_hit();
		test_asid_global();
		test_arbitration();
		test_pipeline();
		test_invalidate();
		$display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: list.f
design/stlb_pkg.sv
design/stlb_req_arbiter.sv
design/stlb_entry_ram.sv
design/stlb_update.sv
design/stlb_translate.sv
design/stlb_top.sv
test/tb_stlb.sv

// File: run.sh
#!/bin/bash
# Build the testbench with Verilator, run it and search the log for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f list.f --top-module tb_stlb -o tb_stlb \
	&& ./obj_dir/tb_stlb > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "\*\*\* TEST PASSED \*\*\*" sim.log && exit 0 || exit 1
